//--- hw/arm_isa_pkg.sv
`default_nettype none

package arm_isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 4;
    localparam int reg_count  = 15;

    localparam logic [xlen-1:0] pc_step = 32'd4;

    // major opcodes
    localparam logic [1:0] op_dp  = 2'b00;
    localparam logic [1:0] op_mem = 2'b01;

    // data processing commands
    localparam logic [3:0] cmd_and = 4'b0000;
    localparam logic [3:0] cmd_sub = 4'b0010;
    localparam logic [3:0] cmd_add = 4'b0100;
    localparam logic [3:0] cmd_orr = 4'b1100;
    localparam logic [3:0] cmd_mov = 4'b1101;

    // shift types
    localparam logic [1:0] sh_lsl = 2'b00;
    localparam logic [1:0] sh_lsr = 2'b01;
    localparam logic [1:0] sh_asr = 2'b10;
    localparam logic [1:0] sh_ror = 2'b11;

    // op 11 never decodes, so this word travels as a bubble
    localparam logic [xlen-1:0] bubble_instr = 32'h0c00_0000;

    //////////////////////////////
    // instruction views

    typedef struct packed {
        logic [3:0]            cond;
        logic [1:0]            op;
        logic                  i;
        logic [3:0]            cmd;
        logic                  s;
        logic [reg_addr_w-1:0] rn;
        logic [reg_addr_w-1:0] rd;
        logic [3:0]            rot;
        logic [7:0]            imm8;
    } dp_imm_t;

    typedef struct packed {
        logic [3:0]            cond;
        logic [1:0]            op;
        logic                  i;
        logic [3:0]            cmd;
        logic                  s;
        logic [reg_addr_w-1:0] rn;
        logic [reg_addr_w-1:0] rd;
        logic [4:0]            shamt5;
        logic [1:0]            sh;
        logic                  reg_shift;
        logic [reg_addr_w-1:0] rm;
    } dp_reg_t;

    typedef struct packed {
        logic [3:0]            cond;
        logic [1:0]            op;
        logic                  i;
        logic                  p;
        logic                  u;
        logic                  b;
        logic                  w;
        logic                  l;
        logic [reg_addr_w-1:0] rn;
        logic [reg_addr_w-1:0] rd;
        logic [11:0]           imm12;
    } mem_t;

    // op and i pick the view that applies
    typedef union packed {
        dp_imm_t dp_imm;
        dp_reg_t dp_reg;
        mem_t    mem;
    } instr_u;

endpackage

`default_nettype wire

//--- hw/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    //////////////////////////////
    // stage bundles

    typedef struct packed {
        logic                               valid;
        logic                               reg_write;
        logic                               mem_to_reg;
        logic                               mem_write;
        logic                               use_imm;
        logic [3:0]                         alu_cmd;
        logic [1:0]                         sh;
        logic [4:0]                         shamt;
        logic [arm_isa_pkg::reg_addr_w-1:0] rn;
        logic [arm_isa_pkg::reg_addr_w-1:0] rm;
        logic [arm_isa_pkg::reg_addr_w-1:0] rd;
        logic [arm_isa_pkg::xlen-1:0]       rd1;
        logic [arm_isa_pkg::xlen-1:0]       rd2;
        logic [arm_isa_pkg::xlen-1:0]       imm;
    } dec_ex_t;

    typedef struct packed {
        logic                               reg_write;
        logic                               mem_to_reg;
        logic                               mem_write;
        logic [arm_isa_pkg::reg_addr_w-1:0] rd;
        logic [arm_isa_pkg::xlen-1:0]       alu_result;
        logic [arm_isa_pkg::xlen-1:0]       write_data;
    } ex_mem_t;

    typedef struct packed {
        logic                               reg_write;
        logic                               mem_to_reg;
        logic [arm_isa_pkg::reg_addr_w-1:0] rd;
        logic [arm_isa_pkg::xlen-1:0]       alu_out;
        logic [arm_isa_pkg::xlen-1:0]       read_data;
    } mem_wb_t;

    // data memory port
    typedef struct packed {
        logic                         we;
        logic [arm_isa_pkg::xlen-1:0] addr;
        logic [arm_isa_pkg::xlen-1:0] wdata;
    } dmem_req_t;

    // operand source in execute
    typedef logic [1:0] fwd_sel_t;

    localparam fwd_sel_t fwd_reg = 2'b00;
    localparam fwd_sel_t fwd_wb  = 2'b01;
    localparam fwd_sel_t fwd_mem = 2'b10;

endpackage

`default_nettype wire

//--- hw/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         stall,
    input  logic [arm_isa_pkg::xlen-1:0] imem_data,
    output logic [arm_isa_pkg::xlen-1:0] pc,
    output arm_isa_pkg::instr_u          instr_f
);
    import arm_isa_pkg::*;

    // pc and fetched word move together, both frozen by a load-use stall
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc      <= '0;
            instr_f <= bubble_instr;
        end else if (!stall) begin
            pc      <= pc + pc_step;
            instr_f <= imem_data;
        end
    end

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [arm_isa_pkg::reg_addr_w-1:0] ra1,
    input  logic [arm_isa_pkg::reg_addr_w-1:0] ra2,
    output logic [arm_isa_pkg::xlen-1:0]       rd1,
    output logic [arm_isa_pkg::xlen-1:0]       rd2,
    input  logic                               wb_en,
    input  logic [arm_isa_pkg::reg_addr_w-1:0] wb_rd,
    input  logic [arm_isa_pkg::xlen-1:0]       wb_data
);
    import arm_isa_pkg::*;

    logic [xlen-1:0] regs [reg_count];

    // r0 to r14 only, r15 has no storage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < reg_count; k++) begin
                regs[k] <= '0;
            end
        end else if (wb_en && wb_rd < reg_count) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign rd1 = (wb_en && wb_rd == ra1) ? wb_data :
                 (ra1 < reg_count)       ? regs[ra1] : '0;
    assign rd2 = (wb_en && wb_rd == ra2) ? wb_data :
                 (ra2 < reg_count)       ? regs[ra2] : '0;

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               stall,
    input  arm_isa_pkg::instr_u                instr_f,
    input  logic                               wb_en,
    input  logic [arm_isa_pkg::reg_addr_w-1:0] wb_rd,
    input  logic [arm_isa_pkg::xlen-1:0]       wb_data,
    output logic [arm_isa_pkg::reg_addr_w-1:0] ra1,
    output logic [arm_isa_pkg::reg_addr_w-1:0] ra2,
    output logic                               uses_rm,
    output pipe_pkg::dec_ex_t                  dec_ex
);
    import arm_isa_pkg::*;
    import pipe_pkg::*;

    logic            is_dp;
    logic            is_mem;
    logic            dp_known;
    logic            mem_known;
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
    dec_ex_t         dec_next;

    assign is_dp  = (instr_f.dp_imm.op == op_dp);
    assign is_mem = (instr_f.mem.op == op_mem);

    // register form only with a constant shift amount
    always_comb begin
        case (instr_f.dp_imm.cmd)
            cmd_and, cmd_sub, cmd_add, cmd_orr, cmd_mov:
                dp_known = instr_f.dp_imm.i || !instr_f.dp_reg.reg_shift;
            default:
                dp_known = 1'b0;
        endcase
    end

    // word access, pre-indexed, positive offset, no base writeback
    assign mem_known = !instr_f.mem.i && instr_f.mem.p && instr_f.mem.u &&
                       !instr_f.mem.b && !instr_f.mem.w;

    //////////////////////////////
    // register reads

    // STR takes its data register through port 2
    assign ra1     = instr_f.dp_reg.rn;
    assign ra2     = is_mem ? instr_f.mem.rd : instr_f.dp_reg.rm;
    assign uses_rm = (is_dp && !instr_f.dp_reg.i) || (is_mem && !instr_f.mem.l);

    reg_file u_reg_file (
        .clk     (clk),
        .reset   (reset),
        .ra1     (ra1),
        .ra2     (ra2),
        .rd1     (rd1),
        .rd2     (rd2),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

    //////////////////////////////
    // control and immediate

    always_comb begin
        dec_next       = '0;
        dec_next.rn    = ra1;
        dec_next.rm    = ra2;
        dec_next.rd    = instr_f.dp_imm.rd;
        dec_next.rd1   = rd1;
        dec_next.rd2   = rd2;
        dec_next.sh    = instr_f.dp_reg.sh;
        dec_next.shamt = instr_f.dp_reg.shamt5;
        if (is_dp && dp_known) begin
            dec_next.valid     = 1'b1;
            dec_next.reg_write = 1'b1;
            dec_next.use_imm   = instr_f.dp_imm.i;
            dec_next.alu_cmd   = instr_f.dp_imm.cmd;
            // rot field not applied
            dec_next.imm       = {{(xlen-8){1'b0}}, instr_f.dp_imm.imm8};
        end else if (is_mem && mem_known) begin
            dec_next.valid      = 1'b1;
            dec_next.reg_write  = instr_f.mem.l;
            dec_next.mem_to_reg = instr_f.mem.l;
            dec_next.mem_write  = !instr_f.mem.l;
            dec_next.use_imm    = 1'b1;
            dec_next.alu_cmd    = cmd_add;
            dec_next.imm        = {{(xlen-12){1'b0}}, instr_f.mem.imm12};
        end
    end

    // a stall sends a bubble down while fetch holds the instruction
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dec_ex <= '0;
        end else if (stall) begin
            dec_ex <= '0;
        end else begin
            dec_ex <= dec_next;
        end
    end

endmodule

`default_nettype wire

//--- hw/barrel_shifter.sv
`timescale 1ns/10ps
`default_nettype none

module barrel_shifter (
    input  logic [arm_isa_pkg::xlen-1:0] value,
    input  logic [1:0]                   sh,
    input  logic [4:0]                   shamt,
    output logic [arm_isa_pkg::xlen-1:0] shifted
);
    import arm_isa_pkg::*;

    logic [2*xlen-1:0] rotated;

    // doubled word shifted right gives the rotation in the low half
    assign rotated = {value, value} >> shamt;

    // zero amount leaves the value unchanged for every type
    always_comb begin
        case (sh)
            sh_lsl:  shifted = value << shamt;
            sh_lsr:  shifted = value >> shamt;
            sh_asr:  shifted = $signed(value) >>> shamt;
            default: shifted = rotated[xlen-1:0];
        endcase
    end

endmodule

`default_nettype wire

//--- hw/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  logic                         clk,
    input  logic                         reset,
    input  pipe_pkg::dec_ex_t            dec_ex,
    input  pipe_pkg::fwd_sel_t           fwd_a,
    input  pipe_pkg::fwd_sel_t           fwd_b,
    input  logic [arm_isa_pkg::xlen-1:0] wb_data,
    output pipe_pkg::ex_mem_t            ex_mem
);
    import arm_isa_pkg::*;
    import pipe_pkg::*;

    logic [xlen-1:0] src_a;
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] shifted_b;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_result;
    ex_mem_t         ex_next;

    //////////////////////////////
    // operand forwarding

    assign src_a = (fwd_a == fwd_mem) ? ex_mem.alu_result :
                   (fwd_a == fwd_wb)  ? wb_data : dec_ex.rd1;
    assign src_b = (fwd_b == fwd_mem) ? ex_mem.alu_result :
                   (fwd_b == fwd_wb)  ? wb_data : dec_ex.rd2;

    barrel_shifter u_barrel_shifter (
        .value   (src_b),
        .sh      (dec_ex.sh),
        .shamt   (dec_ex.shamt),
        .shifted (shifted_b)
    );

    assign op_b = dec_ex.use_imm ? dec_ex.imm : shifted_b;

    // loads and stores come through here as add for the address
    always_comb begin
        case (dec_ex.alu_cmd)
            cmd_and: alu_result = src_a & op_b;
            cmd_sub: alu_result = src_a - op_b;
            cmd_add: alu_result = src_a + op_b;
            cmd_orr: alu_result = src_a | op_b;
            cmd_mov: alu_result = op_b;
            default: alu_result = '0;
        endcase
    end

    always_comb begin
        ex_next.reg_write  = dec_ex.valid && dec_ex.reg_write;
        ex_next.mem_to_reg = dec_ex.valid && dec_ex.mem_to_reg;
        ex_next.mem_write  = dec_ex.valid && dec_ex.mem_write;
        ex_next.rd         = dec_ex.rd;
        ex_next.alu_result = alu_result;
        // store data is the unshifted register
        ex_next.write_data = src_b;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= ex_next;
        end
    end

endmodule

`default_nettype wire

//--- hw/hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
    input  logic [arm_isa_pkg::reg_addr_w-1:0] ra1,
    input  logic [arm_isa_pkg::reg_addr_w-1:0] ra2,
    input  logic                               uses_rm,
    input  pipe_pkg::dec_ex_t                  dec_ex,
    input  pipe_pkg::ex_mem_t                  ex_mem,
    input  logic                               wb_en,
    input  logic [arm_isa_pkg::reg_addr_w-1:0] wb_rd,
    output pipe_pkg::fwd_sel_t                 fwd_a,
    output pipe_pkg::fwd_sel_t                 fwd_b,
    output logic                               stall
);
    import pipe_pkg::*;

    // memory stage first, it holds the younger result
    assign fwd_a = (ex_mem.reg_write && ex_mem.rd == dec_ex.rn) ? fwd_mem :
                   (wb_en && wb_rd == dec_ex.rn)                ? fwd_wb  : fwd_reg;
    assign fwd_b = (ex_mem.reg_write && ex_mem.rd == dec_ex.rm) ? fwd_mem :
                   (wb_en && wb_rd == dec_ex.rm)                ? fwd_wb  : fwd_reg;

    // load data only exists after the memory stage, so wait one cycle
    assign stall = dec_ex.valid && dec_ex.mem_to_reg &&
                   (dec_ex.rd == ra1 || (uses_rm && dec_ex.rd == ra2));

endmodule

`default_nettype wire

//--- hw/mem_wb_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_wb_stage (
    input  logic                               clk,
    input  logic                               reset,
    input  pipe_pkg::ex_mem_t                  ex_mem,
    input  logic [arm_isa_pkg::xlen-1:0]       dmem_rdata,
    output logic                               wb_en,
    output logic [arm_isa_pkg::reg_addr_w-1:0] wb_rd,
    output logic [arm_isa_pkg::xlen-1:0]       wb_data
);
    import pipe_pkg::*;

    mem_wb_t mem_wb;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_wb <= '0;
        end else begin
            mem_wb <= '{
                reg_write:  ex_mem.reg_write,
                mem_to_reg: ex_mem.mem_to_reg,
                rd:         ex_mem.rd,
                alu_out:    ex_mem.alu_result,
                read_data:  dmem_rdata
            };
        end
    end

    // write-back bus, also the oldest forwarding source
    assign wb_en   = mem_wb.reg_write;
    assign wb_rd   = mem_wb.rd;
    assign wb_data = mem_wb.mem_to_reg ? mem_wb.read_data : mem_wb.alu_out;

endmodule

`default_nettype wire

//--- hw/arm_pipeline.sv
`timescale 1ns/10ps
`default_nettype none

module arm_pipeline (
    input  logic                         clk,
    input  logic                         reset,
    output logic [arm_isa_pkg::xlen-1:0] imem_addr,
    input  logic [arm_isa_pkg::xlen-1:0] imem_data,
    output pipe_pkg::dmem_req_t          dmem_req,
    input  logic [arm_isa_pkg::xlen-1:0] dmem_rdata
);
    import arm_isa_pkg::*;
    import pipe_pkg::*;

    instr_u                instr_f;
    logic                  stall;
    logic [reg_addr_w-1:0] ra1;
    logic [reg_addr_w-1:0] ra2;
    logic                  uses_rm;
    dec_ex_t               dec_ex;
    ex_mem_t               ex_mem;
    fwd_sel_t              fwd_a;
    fwd_sel_t              fwd_b;
    logic                  wb_en;
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_data;

    //////////////////////////////
    // stages

    fetch_stage u_fetch (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .imem_data (imem_data),
        .pc        (imem_addr),
        .instr_f   (instr_f)
    );

    decode_stage u_decode (
        .clk     (clk),
        .reset   (reset),
        .stall   (stall),
        .instr_f (instr_f),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data),
        .ra1     (ra1),
        .ra2     (ra2),
        .uses_rm (uses_rm),
        .dec_ex  (dec_ex)
    );

    execute_stage u_execute (
        .clk     (clk),
        .reset   (reset),
        .dec_ex  (dec_ex),
        .fwd_a   (fwd_a),
        .fwd_b   (fwd_b),
        .wb_data (wb_data),
        .ex_mem  (ex_mem)
    );

    hazard_unit u_hazard (
        .ra1     (ra1),
        .ra2     (ra2),
        .uses_rm (uses_rm),
        .dec_ex  (dec_ex),
        .ex_mem  (ex_mem),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .fwd_a   (fwd_a),
        .fwd_b   (fwd_b),
        .stall   (stall)
    );

    // memory stage is the ex_mem register driving the data port
    assign dmem_req.we    = ex_mem.mem_write;
    assign dmem_req.addr  = ex_mem.alu_result;
    assign dmem_req.wdata = ex_mem.write_data;

    mem_wb_stage u_mem_wb (
        .clk        (clk),
        .reset      (reset),
        .ex_mem     (ex_mem),
        .dmem_rdata (dmem_rdata),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

endmodule

`default_nettype wire

//--- verif/arm_pipeline_tb.sv
`timescale 1ns/10ps
`default_nettype none

module arm_pipeline_tb;
    import pipe_pkg::*;

    localparam int mem_words = 256;

    logic             clk;
    logic             reset;
    logic [31:0]      imem_addr;
    logic [31:0]      imem_data;
    dmem_req_t        dmem_req;
    logic [31:0]      dmem_rdata;

    logic [31:0]      imem [mem_words];
    logic [31:0]      dmem [mem_words];

    // expected stores in program order
    logic [31:0]      exp_addr [$];
    logic [31:0]      exp_data [$];
    int               prog_words;

    arm_pipeline u_dut (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////
    // memory models

    // word-addressed combinational reads
    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_req.addr[9:2]];

    always @(posedge clk) begin
        if (!reset && dmem_req.we) begin
            dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
        end
    end

    //////////////////////////////
    // helpers

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0d ns: %s = %h, expected %h", $time, name, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // I, M and S lines are kept and all other lines skipped
    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        string       kind;
        logic [31:0] a;
        logic [31:0] d;
        prog_words = 0;
        for (int k = 0; k < mem_words; k++) begin
            imem[k] = '0;
            // background data built from the word index
            dmem[k] = {16'hd05e, k[7:0], ~k[7:0]};
        end
        fd = $fopen("verif/pipeline_tests.mem", "r");
        if (fd == 0) begin
            $display("could not open verif/pipeline_tests.mem");
            $display("Simulation finished: FAIL");
            $fatal(1, "missing test file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                kind = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%s %h %h", kind, a, d);
                if (n >= 2 && kind == "I") begin
                    imem[prog_words] = a;
                    prog_words++;
                end else if (n >= 3 && kind == "M") begin
                    dmem[a[9:2]] = d;
                end else if (n >= 3 && kind == "S") begin
                    exp_addr.push_back(a);
                    exp_data.push_back(d);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_store();
        logic [31:0] a;
        logic [31:0] d;
        a = exp_addr.pop_front();
        d = exp_data.pop_front();
        check_value("dmem_req.addr", dmem_req.addr, a);
        check_value("dmem_req.wdata", dmem_req.wdata, d);
    endtask

    //////////////////////////////
    // main sequence

    initial begin
        int cycles;
        int limit;
        reset = 1'b1;
        load_tests();
        limit  = 4 * prog_words + 50;
        cycles = 0;
        if (exp_addr.size() == 0) begin
            $display("test file holds no expected stores");
            $display("Simulation finished: FAIL");
            $fatal(1, "empty test file");
        end else begin
            repeat (4) @(posedge clk);
            @(negedge clk);
            reset = 1'b0;
            // store port looked at once per cycle on the falling edge
            while (exp_addr.size() > 0 && cycles < limit) begin
                @(negedge clk);
                cycles++;
                if (dmem_req.we) begin
                    check_store();
                end
            end
            if (exp_addr.size() == 0) begin
                $display("Simulation finished: PASS");
                $finish;
            end else begin
                $display("timeout after %0d cycles with %0d stores never seen",
                         cycles, exp_addr.size());
                $display("Simulation finished: FAIL");
                $fatal(1, "timeout");
            end
        end
    end

endmodule

`default_nettype wire

//--- src.f
hw/arm_isa_pkg.sv
hw/pipe_pkg.sv
hw/fetch_stage.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/barrel_shifter.sv
hw/execute_stage.sv
hw/hazard_unit.sv
hw/mem_wb_stage.sv
hw/arm_pipeline.sv
verif/arm_pipeline_tb.sv

//--- verif/pipeline_tests.mem
// columns: I <instruction word> | M <byte address> <data> | S <byte address> <data>
// hex values; I lines in program order, S lines in the order the stores must appear
M 140 12345678
M 144 0000F00D
M 148 A5A55A5A
// immediate operands, sources set several instructions earlier
I E3A0105A  // mov r1, #0x5a
I E3A0200F  // mov r2, #0x0f
I E3A030C3  // mov r3, #0xc3
I E3A0C040  // mov r12, #0x40
I E3A0B080  // mov r11, #0x80
I E2814021  // add r4, r1, #0x21
I E2435013  // sub r5, r3, #0x13
I E201603C  // and r6, r1, #0x3c
I E38270A0  // orr r7, r2, #0xa0
I E58C4000  // str r4, [r12]
I E58C5004  // str r5, [r12, #4]
I E58C6008  // str r6, [r12, #8]
I E58C700C  // str r7, [r12, #0xc]
S 40 0000007B
S 44 000000B0
S 48 00000018
S 4C 000000AF
// forwarding, memory and writeback both hold r8
I E3A08011  // mov r8, #0x11
I E2888022  // add r8, r8, #0x22
I E0889008  // add r9, r8, r8
I E049A008  // sub r10, r9, r8
I E58CA010  // str r10, [r12, #0x10]
I E58C9014  // str r9, [r12, #0x14]
S 50 00000033
S 54 00000066
// constant shifts of 0x81000035
I E3A01081  // mov r1, #0x81
I E1A02C01  // mov r2, r1, lsl #24
I E3822035  // orr r2, r2, #0x35
I E1A03002  // mov r3, r2, lsl #0
I E58B3000  // str r3, [r11]
I E1A04082  // mov r4, r2, lsl #1
I E58B4004  // str r4, [r11, #4]
I E1A03F82  // mov r3, r2, lsl #31
I E58B3008  // str r3, [r11, #8]
I E1A04022  // mov r4, r2, lsr #0
I E58B400C  // str r4, [r11, #0xc]
I E1A030A2  // mov r3, r2, lsr #1
I E58B3010  // str r3, [r11, #0x10]
I E1A04FA2  // mov r4, r2, lsr #31
I E58B4014  // str r4, [r11, #0x14]
I E1A03042  // mov r3, r2, asr #0
I E58B3018  // str r3, [r11, #0x18]
I E1A040C2  // mov r4, r2, asr #1
I E58B401C  // str r4, [r11, #0x1c]
I E1A03FC2  // mov r3, r2, asr #31
I E58B3020  // str r3, [r11, #0x20]
I E1A04062  // mov r4, r2, ror #0
I E58B4024  // str r4, [r11, #0x24]
I E1A030E2  // mov r3, r2, ror #1
I E58B3028  // str r3, [r11, #0x28]
I E1A04FE2  // mov r4, r2, ror #31
I E58B402C  // str r4, [r11, #0x2c]
S 80 81000035
S 84 0200006A
S 88 80000000
S 8C 81000035
S 90 4080001A
S 94 00000001
S 98 81000035
S 9C C080001A
S A0 FFFFFFFF
S A4 81000035
S A8 C080001A
S AC 0200006B
// load followed by a use on rn, rm and store data
I E59C5100  // ldr r5, [r12, #0x100]
I E2857011  // add r7, r5, #0x11
I E58C7018  // str r7, [r12, #0x18]
I E59C6104  // ldr r6, [r12, #0x104]
I E0818006  // add r8, r1, r6
I E58C801C  // str r8, [r12, #0x1c]
I E59C9108  // ldr r9, [r12, #0x108]
I E58C9020  // str r9, [r12, #0x20]
S 58 12345689
S 5C 0000F08E
S 60 A5A55A5A
// unknown words write nothing and store nothing
I E22550FF  // eor r5, r5, #0xff
I E0855115  // add r5, r5, r5, lsl r1
I E5CC2024  // strb r2, [r12, #0x24]
I E50C2028  // str r2, [r12, #-0x28]
I EAFFFFFE  // b .
I E58C5024  // str r5, [r12, #0x24]
I E58C72C0  // str r7, [r12, #0x2c0]
I E59CA024  // ldr r10, [r12, #0x24]
I E24AA078  // sub r10, r10, #0x78
I E58BA030  // str r10, [r11, #0x30]
S 64 12345678
S 300 12345689
S B0 12345600
